// File: common/riscv_v_pkg.sv
// ==============================
// Vector decode package
// Instruction layouts, encodings and the
// control and CSR request types
// ==============================

package riscv_v_pkg;

    typedef logic [31:0] riscv_data_t;
    typedef logic [4:0]  riscv_v_rf_addr_t;
    typedef logic [7:0]  riscv_v_vtype_t;
    typedef logic [31:0] riscv_v_vl_t;

    // OP-V arithmetic layout
    typedef struct packed {
        logic [5:0]       funct6;
        logic             vm;
        riscv_v_rf_addr_t vs2;
        riscv_v_rf_addr_t vs1;
        logic [2:0]       funct3;
        riscv_v_rf_addr_t vd;
        logic [6:0]       opcode;
    } riscv_v_opv_t;

    // vsetvli layout
    typedef struct packed {
        logic             zero;
        logic [10:0]      zimm;
        riscv_v_rf_addr_t rs1;
        logic [2:0]       funct3;
        riscv_v_rf_addr_t rd;
        logic [6:0]       opcode;
    } riscv_v_vcfg_t;

    typedef union packed {
        riscv_v_opv_t  opv;
        riscv_v_vcfg_t vcfg;
    } riscv_v_instr_u;

    localparam logic [6:0] OPC_OPV   = 7'b1010111;

    localparam logic [2:0] F3_OPIVV  = 3'b000;
    localparam logic [2:0] F3_OPIVI  = 3'b011;
    localparam logic [2:0] F3_OPIVX  = 3'b100;
    localparam logic [2:0] F3_OPCFG  = 3'b111;

    localparam logic [5:0] F6_VADD   = 6'b000000;
    localparam logic [5:0] F6_VSUB   = 6'b000010;
    localparam logic [5:0] F6_VAND   = 6'b001001;
    localparam logic [5:0] F6_VOR    = 6'b001010;
    localparam logic [5:0] F6_VXOR   = 6'b001011;

    typedef struct packed {
        logic valid;
        logic is_vector_vector_op;
        logic is_vector_scalar_op;
        logic is_scalar_imm_op;
        logic is_add;
        logic is_sub;
        logic is_and;
        logic is_or;
        logic is_xor;
    } riscv_v_exe_ctrl_t;

    typedef struct packed {
        logic           wr_vl;
        logic           wr_vtype;
        riscv_v_vl_t    vl_data;
        riscv_v_vtype_t vtype_data;
    } riscv_v_csr_req_t;

endpackage

// File: design/riscv_v_ctrl.sv
// ==============================
// Vector instruction decoder
// Decodes OP-V words into registered execute
// control and source/destination addresses
// ==============================

`timescale 1ns/100ps

module riscv_v_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           stall,
    input  logic                           flush,
    input  riscv_v_pkg::riscv_v_instr_u    instruction_id,
    output riscv_v_pkg::riscv_v_rf_addr_t  vs1_id,
    output riscv_v_pkg::riscv_v_rf_addr_t  vs2_id,
    output riscv_v_pkg::riscv_v_rf_addr_t  vd_id,
    output logic                           is_vsetvli_id,
    output riscv_v_pkg::riscv_v_exe_ctrl_t exe_ctrl,
    output riscv_v_pkg::riscv_data_t       imm_exe
);

    riscv_v_pkg::riscv_v_opv_t      opv;
    riscv_v_pkg::riscv_v_exe_ctrl_t exe_ctrl_id;
    riscv_v_pkg::riscv_data_t       imm_id;
    logic                           is_opv;

    assign opv    = instruction_id.opv;
    assign is_opv = (opv.opcode == riscv_v_pkg::OPC_OPV);

    assign vs1_id = opv.vs1;
    assign vs2_id = opv.vs2;
    assign vd_id  = opv.vd;

    // Config form only when bit 31 is clear
    assign is_vsetvli_id = is_opv &&
                           (instruction_id.vcfg.funct3 == riscv_v_pkg::F3_OPCFG) &&
                           !instruction_id.vcfg.zero;

    // Sign extended 5-bit immediate
    assign imm_id = {{27{opv.vs1[4]}}, opv.vs1};

    always_comb begin
        exe_ctrl_id = '0;
        exe_ctrl_id.is_vector_vector_op = (opv.funct3 == riscv_v_pkg::F3_OPIVV);
        exe_ctrl_id.is_vector_scalar_op = (opv.funct3 == riscv_v_pkg::F3_OPIVX);
        exe_ctrl_id.is_scalar_imm_op    = (opv.funct3 == riscv_v_pkg::F3_OPIVI);
        case (opv.funct6)
            riscv_v_pkg::F6_VADD: exe_ctrl_id.is_add = 1'b1;
            riscv_v_pkg::F6_VSUB: exe_ctrl_id.is_sub = 1'b1;
            riscv_v_pkg::F6_VAND: exe_ctrl_id.is_and = 1'b1;
            riscv_v_pkg::F6_VOR:  exe_ctrl_id.is_or  = 1'b1;
            riscv_v_pkg::F6_VXOR: exe_ctrl_id.is_xor = 1'b1;
            default: ;
        endcase
        exe_ctrl_id.valid = is_opv &&
                            (exe_ctrl_id.is_vector_vector_op ||
                             exe_ctrl_id.is_vector_scalar_op ||
                             exe_ctrl_id.is_scalar_imm_op) &&
                            (exe_ctrl_id.is_add || exe_ctrl_id.is_sub ||
                             exe_ctrl_id.is_and || exe_ctrl_id.is_or ||
                             exe_ctrl_id.is_xor);
        // Unknown encodings become bubbles
        if (!exe_ctrl_id.valid) begin
            exe_ctrl_id = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            exe_ctrl <= '0;
        end else if (!stall) begin
            exe_ctrl <= exe_ctrl_id;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            imm_exe <= imm_id;
        end
    end

endmodule

// File: regfile/riscv_v_rf.sv
// ==============================
// Vector register file
// 32 x VLEN, two async reads, one write
// ==============================

`timescale 1ns/100ps

module riscv_v_rf #(
    parameter int VLEN = 64
) (
    input  logic                          clk,
    input  riscv_v_pkg::riscv_v_rf_addr_t wr_addr,
    input  riscv_v_pkg::riscv_v_rf_addr_t rd_addr_a,
    input  riscv_v_pkg::riscv_v_rf_addr_t rd_addr_b,
    input  logic [VLEN-1:0]               data_in,
    input  logic                          wr_en,
    output logic [VLEN-1:0]               data_out_a,
    output logic [VLEN-1:0]               data_out_b
);

    logic [VLEN-1:0] regs [32];

    // v0 is writable like any other register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= data_in;
        end
    end

    assign data_out_a = regs[rd_addr_a];
    assign data_out_b = regs[rd_addr_b];

endmodule

// File: regfile/riscv_v_rf_ctrl.sv
// ==============================
// Register file pipeline control
// Carries operands to exe and the result
// and destination to write-back
// ==============================

`timescale 1ns/100ps

module riscv_v_rf_ctrl #(
    parameter int VLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          flush,
    input  riscv_v_pkg::riscv_v_rf_addr_t rf_wr_addr_id,
    input  logic [VLEN-1:0]               rf_rd_data_srca_id,
    input  logic [VLEN-1:0]               rf_rd_data_srcb_id,
    input  riscv_v_pkg::riscv_data_t      int_rf_rd_data_id,
    input  logic                          alu_valid_exe,
    input  logic [VLEN-1:0]               alu_data_exe,
    output logic [VLEN-1:0]               rf_rd_data_srca_exe,
    output logic [VLEN-1:0]               rf_rd_data_srcb_exe,
    output riscv_v_pkg::riscv_data_t      int_rf_rd_data_exe,
    output riscv_v_pkg::riscv_v_rf_addr_t rf_wr_addr_wb,
    output logic [VLEN-1:0]               rf_wr_data_wb,
    output logic                          rf_wr_en_wb
);

    riscv_v_pkg::riscv_v_rf_addr_t rf_wr_addr_exe;
    logic                          wr_valid_wb;

    always_ff @(posedge clk) begin
        if (!stall) begin
            rf_rd_data_srca_exe <= rf_rd_data_srca_id;
            rf_rd_data_srcb_exe <= rf_rd_data_srcb_id;
            int_rf_rd_data_exe  <= int_rf_rd_data_id;
            rf_wr_addr_exe      <= rf_wr_addr_id;
            rf_wr_addr_wb       <= rf_wr_addr_exe;
            rf_wr_data_wb       <= alu_data_exe;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_valid_wb <= 1'b0;
        end else if (!stall) begin
            wr_valid_wb <= alu_valid_exe;
        end
    end

    // No commit while the pipe is frozen
    assign rf_wr_en_wb = wr_valid_wb & ~stall;

endmodule

// File: csr/riscv_v_csr_ctrl.sv
// ==============================
// CSR write arbiter
// External requests win over vsetvli,
// winner is piped to write-back
// ==============================

`timescale 1ns/100ps

module riscv_v_csr_ctrl #(
    parameter int VLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          flush,
    input  riscv_v_pkg::riscv_v_csr_req_t ext_csr_req_id,
    input  riscv_v_pkg::riscv_v_instr_u   instruction_id,
    input  logic                          is_vsetvli_id,
    input  riscv_v_pkg::riscv_data_t      int_rf_rd_data_id,
    output riscv_v_pkg::riscv_v_csr_req_t csr_req_wb,
    output riscv_v_pkg::riscv_data_t      int_rf_wr_data_wb,
    output logic                          int_rf_wr_en_wb
);

    localparam riscv_v_pkg::riscv_v_vl_t VLMAX = riscv_v_pkg::riscv_v_vl_t'(VLEN / 8);

    riscv_v_pkg::riscv_v_csr_req_t vset_req_id;
    riscv_v_pkg::riscv_v_csr_req_t csr_req_id;
    riscv_v_pkg::riscv_v_csr_req_t csr_req_exe;
    riscv_v_pkg::riscv_v_csr_req_t csr_req_q;
    riscv_v_pkg::riscv_v_vl_t      new_vl_id;
    riscv_v_pkg::riscv_data_t      int_rf_wr_data_exe;
    logic                          int_rf_wr_en_id;
    logic                          int_rf_wr_en_exe;
    logic                          int_rf_wr_en_q;

    // AVL clamped to VLMAX
    assign new_vl_id = (int_rf_rd_data_id < VLMAX) ? int_rf_rd_data_id : VLMAX;

    assign vset_req_id.wr_vl      = is_vsetvli_id;
    assign vset_req_id.wr_vtype   = is_vsetvli_id;
    assign vset_req_id.vl_data    = new_vl_id;
    assign vset_req_id.vtype_data = instruction_id.vcfg.zimm[7:0];

    // Fixed priority, external first
    assign csr_req_id = (ext_csr_req_id.wr_vl || ext_csr_req_id.wr_vtype) ?
                        ext_csr_req_id : vset_req_id;

    assign int_rf_wr_en_id = is_vsetvli_id && (instruction_id.vcfg.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            csr_req_exe      <= '0;
            csr_req_q        <= '0;
            int_rf_wr_en_exe <= 1'b0;
            int_rf_wr_en_q   <= 1'b0;
        end else if (!stall) begin
            csr_req_exe      <= csr_req_id;
            csr_req_q        <= csr_req_exe;
            int_rf_wr_en_exe <= int_rf_wr_en_id;
            int_rf_wr_en_q   <= int_rf_wr_en_exe;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            int_rf_wr_data_exe <= new_vl_id;
            int_rf_wr_data_wb  <= int_rf_wr_data_exe;
        end
    end

    always_comb begin
        csr_req_wb          = csr_req_q;
        csr_req_wb.wr_vl    = csr_req_q.wr_vl & ~stall;
        csr_req_wb.wr_vtype = csr_req_q.wr_vtype & ~stall;
    end

    assign int_rf_wr_en_wb = int_rf_wr_en_q & ~stall;

endmodule

// File: csr/riscv_v_csr.sv
// ==============================
// Vector CSRs
// vl and vtype registers, constant vlenb
// ==============================

`timescale 1ns/100ps

module riscv_v_csr #(
    parameter int VLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  riscv_v_pkg::riscv_v_csr_req_t csr_req_wb,
    output riscv_v_pkg::riscv_v_vl_t      vl,
    output riscv_v_pkg::riscv_v_vtype_t   vtype,
    output riscv_v_pkg::riscv_data_t      vlenb
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vl <= '0;
        end else if (csr_req_wb.wr_vl) begin
            vl <= csr_req_wb.vl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vtype <= '0;
        end else if (csr_req_wb.wr_vtype) begin
            vtype <= csr_req_wb.vtype_data;
        end
    end

    // Register width in bytes
    assign vlenb = riscv_v_pkg::riscv_data_t'(VLEN / 8);

endmodule

// File: design/riscv_v_decode.sv
// ==============================
// Vector decode stage top level
// Decoder, register file and CSR path
// ==============================

`timescale 1ns/100ps

module riscv_v_decode #(
    parameter int VLEN = 64
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear_pipe,
    input  logic                           riscv_stall,
    input  riscv_v_pkg::riscv_v_instr_u    instruction_id,
    input  riscv_v_pkg::riscv_data_t       int_rf_rd_data_id,
    input  riscv_v_pkg::riscv_v_csr_req_t  ext_csr_req_id,
    input  logic                           alu_valid_exe,
    input  logic [VLEN-1:0]                alu_data_exe,
    output riscv_v_pkg::riscv_v_exe_ctrl_t exe_ctrl,
    output riscv_v_pkg::riscv_data_t       imm_exe,
    output riscv_v_pkg::riscv_data_t       int_rf_rd_data_exe,
    output logic [VLEN-1:0]                rf_rd_data_srca_exe,
    output logic [VLEN-1:0]                rf_rd_data_srcb_exe,
    output riscv_v_pkg::riscv_data_t       int_rf_wr_data_wb,
    output logic                           int_rf_wr_en_wb,
    output riscv_v_pkg::riscv_v_vl_t       vl,
    output riscv_v_pkg::riscv_v_vtype_t    vtype,
    output riscv_v_pkg::riscv_data_t       vlenb
);

    riscv_v_pkg::riscv_v_rf_addr_t vs1_id;
    riscv_v_pkg::riscv_v_rf_addr_t vs2_id;
    riscv_v_pkg::riscv_v_rf_addr_t vd_id;
    riscv_v_pkg::riscv_v_rf_addr_t rf_wr_addr_wb;
    riscv_v_pkg::riscv_v_csr_req_t csr_req_wb;
    logic [VLEN-1:0]               rf_rd_data_srca_id;
    logic [VLEN-1:0]               rf_rd_data_srcb_id;
    logic [VLEN-1:0]               rf_wr_data_wb;
    logic                          rf_wr_en_wb;
    logic                          is_vsetvli_id;

    riscv_v_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (riscv_stall),
        .flush          (clear_pipe),
        .instruction_id (instruction_id),
        .vs1_id         (vs1_id),
        .vs2_id         (vs2_id),
        .vd_id          (vd_id),
        .is_vsetvli_id  (is_vsetvli_id),
        .exe_ctrl       (exe_ctrl),
        .imm_exe        (imm_exe)
    );

    riscv_v_rf #(.VLEN(VLEN)) u_rf (
        .clk        (clk),
        .wr_addr    (rf_wr_addr_wb),
        .rd_addr_a  (vs1_id),
        .rd_addr_b  (vs2_id),
        .data_in    (rf_wr_data_wb),
        .wr_en      (rf_wr_en_wb),
        .data_out_a (rf_rd_data_srca_id),
        .data_out_b (rf_rd_data_srcb_id)
    );

    riscv_v_rf_ctrl #(.VLEN(VLEN)) u_rf_ctrl (
        .clk                 (clk),
        .rst_n               (rst_n),
        .stall               (riscv_stall),
        .flush               (clear_pipe),
        .rf_wr_addr_id       (vd_id),
        .rf_rd_data_srca_id  (rf_rd_data_srca_id),
        .rf_rd_data_srcb_id  (rf_rd_data_srcb_id),
        .int_rf_rd_data_id   (int_rf_rd_data_id),
        .alu_valid_exe       (alu_valid_exe),
        .alu_data_exe        (alu_data_exe),
        .rf_rd_data_srca_exe (rf_rd_data_srca_exe),
        .rf_rd_data_srcb_exe (rf_rd_data_srcb_exe),
        .int_rf_rd_data_exe  (int_rf_rd_data_exe),
        .rf_wr_addr_wb       (rf_wr_addr_wb),
        .rf_wr_data_wb       (rf_wr_data_wb),
        .rf_wr_en_wb         (rf_wr_en_wb)
    );

    riscv_v_csr_ctrl #(.VLEN(VLEN)) u_csr_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall             (riscv_stall),
        .flush             (clear_pipe),
        .ext_csr_req_id    (ext_csr_req_id),
        .instruction_id    (instruction_id),
        .is_vsetvli_id     (is_vsetvli_id),
        .int_rf_rd_data_id (int_rf_rd_data_id),
        .csr_req_wb        (csr_req_wb),
        .int_rf_wr_data_wb (int_rf_wr_data_wb),
        .int_rf_wr_en_wb   (int_rf_wr_en_wb)
    );

    riscv_v_csr #(.VLEN(VLEN)) u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_req_wb (csr_req_wb),
        .vl         (vl),
        .vtype      (vtype),
        .vlenb      (vlenb)
    );

endmodule

// File: test/riscv_v_model.svh
// ==============================
// Vector decode reference model
// Decode, execute and vl clamp rules
// ==============================

`ifndef RISCV_V_MODEL_SVH
`define RISCV_V_MODEL_SVH

logic [31:0] lcg_state = 32'd49439;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
endfunction

// Expected flags, all zero for anything that is not a supported OP-V op
function automatic riscv_v_pkg::riscv_v_exe_ctrl_t decode_ref(input logic [31:0] w);
    riscv_v_pkg::riscv_v_exe_ctrl_t c;
    logic form_ok;
    logic op_ok;
    c = '0;
    c.is_vector_vector_op = (w[14:12] == riscv_v_pkg::F3_OPIVV);
    c.is_vector_scalar_op = (w[14:12] == riscv_v_pkg::F3_OPIVX);
    c.is_scalar_imm_op    = (w[14:12] == riscv_v_pkg::F3_OPIVI);
    c.is_add = (w[31:26] == riscv_v_pkg::F6_VADD);
    c.is_sub = (w[31:26] == riscv_v_pkg::F6_VSUB);
    c.is_and = (w[31:26] == riscv_v_pkg::F6_VAND);
    c.is_or  = (w[31:26] == riscv_v_pkg::F6_VOR);
    c.is_xor = (w[31:26] == riscv_v_pkg::F6_VXOR);
    form_ok = c.is_vector_vector_op | c.is_vector_scalar_op | c.is_scalar_imm_op;
    op_ok   = c.is_add | c.is_sub | c.is_and | c.is_or | c.is_xor;
    c.valid = (w[6:0] == riscv_v_pkg::OPC_OPV) && form_ok && op_ok;
    if (!c.valid) begin
        c = '0;
    end
    return c;
endfunction

// 32-bit lanes, vs2 is the left operand
function automatic logic [VLEN-1:0] exec_op(input riscv_v_pkg::riscv_v_exe_ctrl_t c,
                                            input logic [VLEN-1:0] a,
                                            input logic [VLEN-1:0] b,
                                            input logic [31:0] s,
                                            input logic [31:0] imm);
    logic [VLEN-1:0] r;
    logic [31:0]     x;
    logic [31:0]     y;
    integer          i;
    r = '0;
    for (i = 0; i < VLEN / 32; i = i + 1) begin
        y = b[i*32 +: 32];
        x = c.is_vector_vector_op ? a[i*32 +: 32] : (c.is_vector_scalar_op ? s : imm);
        if (c.is_add) r[i*32 +: 32] = y + x;
        else if (c.is_sub) r[i*32 +: 32] = y - x;
        else if (c.is_and) r[i*32 +: 32] = y & x;
        else if (c.is_or) r[i*32 +: 32] = y | x;
        else if (c.is_xor) r[i*32 +: 32] = y ^ x;
    end
    return r;
endfunction

function automatic logic [31:0] vl_clamp(input logic [31:0] avl);
    return (avl < 32'(VLEN / 8)) ? avl : 32'(VLEN / 8);
endfunction

`endif

// File: test/riscv_v_decode_tb.sv
// ==============================
// Vector decode stage testbench
// Random OP-V traffic against a shadow model
// ==============================

`timescale 1ns/100ps

module riscv_v_decode_tb;

    localparam int VLEN   = 64;
    localparam int N_ALU  = 150;
    localparam int N_DEC  = 200;
    localparam int N_VSET = 40;
    localparam int N_ARB  = 10;
    localparam int N_SF   = 10;
    localparam int TEST_CYCLES = 8 + 96 + 96 + N_ALU * 3 + N_DEC + N_VSET * 4 +
                                 N_ARB * 4 + N_SF * 18 + 10;
    localparam logic [31:0] BUBBLE = 32'h00000013;

    `include "riscv_v_model.svh"

    typedef struct packed {
        riscv_v_pkg::riscv_v_exe_ctrl_t ctrl;
        logic [31:0]                    imm;
        logic [31:0]                    int_val;
        logic [4:0]                     vd;
        logic [VLEN-1:0]                srca;
        logic [VLEN-1:0]                srcb;
        logic [VLEN-1:0]                result;
        logic                           a_known;
        logic                           b_known;
        logic                           res_known;
    } exe_rec_t;

    typedef struct packed {
        riscv_v_pkg::riscv_v_csr_req_t req;
        logic                          int_en;
        logic [31:0]                   int_data;
    } csr_rec_t;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           clear_pipe;
    logic                           riscv_stall;
    riscv_v_pkg::riscv_v_instr_u    instruction_id;
    riscv_v_pkg::riscv_data_t       int_rf_rd_data_id;
    riscv_v_pkg::riscv_v_csr_req_t  ext_csr_req_id;
    logic                           alu_valid_exe;
    logic [VLEN-1:0]                alu_data_exe;
    riscv_v_pkg::riscv_v_exe_ctrl_t exe_ctrl;
    riscv_v_pkg::riscv_data_t       imm_exe;
    riscv_v_pkg::riscv_data_t       int_rf_rd_data_exe;
    logic [VLEN-1:0]                rf_rd_data_srca_exe;
    logic [VLEN-1:0]                rf_rd_data_srcb_exe;
    riscv_v_pkg::riscv_data_t       int_rf_wr_data_wb;
    logic                           int_rf_wr_en_wb;
    riscv_v_pkg::riscv_v_vl_t       vl;
    riscv_v_pkg::riscv_v_vtype_t    vtype;
    riscv_v_pkg::riscv_data_t       vlenb;

    logic [VLEN-1:0] shadow [32];
    logic            known [32];
    logic [31:0]     sh_vl;
    logic [7:0]      sh_vtype;
    exe_rec_t        exe_r;
    exe_rec_t        wb_r;
    exe_rec_t        nxt_exe;
    csr_rec_t        csr_exe;
    csr_rec_t        csr_wb;
    csr_rec_t        nxt_csr;
    logic [31:0]     w;
    logic            vset;
    int              cycles;
    int              err_ctrl;
    int              err_data;
    int              err_csr;

    riscv_v_decode #(.VLEN(VLEN)) uut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .clear_pipe          (clear_pipe),
        .riscv_stall         (riscv_stall),
        .instruction_id      (instruction_id),
        .int_rf_rd_data_id   (int_rf_rd_data_id),
        .ext_csr_req_id      (ext_csr_req_id),
        .alu_valid_exe       (alu_valid_exe),
        .alu_data_exe        (alu_data_exe),
        .exe_ctrl            (exe_ctrl),
        .imm_exe             (imm_exe),
        .int_rf_rd_data_exe  (int_rf_rd_data_exe),
        .rf_rd_data_srca_exe (rf_rd_data_srca_exe),
        .rf_rd_data_srcb_exe (rf_rd_data_srcb_exe),
        .int_rf_wr_data_wb   (int_rf_wr_data_wb),
        .int_rf_wr_en_wb     (int_rf_wr_en_wb),
        .vl                  (vl),
        .vtype               (vtype),
        .vlenb               (vlenb)
    );

    always #10 clk = ~clk;

    // Execute unit answers in the same cycle
    always_comb begin
        alu_valid_exe = exe_ctrl.valid;
        alu_data_exe  = exec_op(exe_ctrl, rf_rd_data_srca_exe, rf_rd_data_srcb_exe,
                                int_rf_rd_data_exe, imm_exe);
    end

    // Shadow pipeline steps once per unstalled edge
    always @(posedge clk) begin
        if (!rst_n) begin
            exe_r    = '0;
            wb_r     = '0;
            csr_exe  = '0;
            csr_wb   = '0;
            sh_vl    = '0;
            sh_vtype = '0;
        end else if (!riscv_stall) begin
            w = instruction_id;
            nxt_exe.ctrl    = decode_ref(w);
            nxt_exe.imm     = {{27{w[19]}}, w[19:15]};
            nxt_exe.int_val = int_rf_rd_data_id;
            nxt_exe.vd      = w[11:7];
            nxt_exe.srca    = shadow[w[19:15]];
            nxt_exe.srcb    = shadow[w[24:20]];
            nxt_exe.a_known = known[w[19:15]];
            nxt_exe.b_known = known[w[24:20]];
            nxt_exe.result  = exec_op(nxt_exe.ctrl, nxt_exe.srca, nxt_exe.srcb,
                                      nxt_exe.int_val, nxt_exe.imm);
            nxt_exe.res_known = nxt_exe.b_known &&
                                (nxt_exe.a_known || !nxt_exe.ctrl.is_vector_vector_op);
            // Masking with zero defines the result even from an unwritten source
            if (nxt_exe.ctrl.is_and && nxt_exe.ctrl.is_scalar_imm_op && nxt_exe.imm == 0) begin
                nxt_exe.res_known = 1'b1;
            end
            vset = (w[6:0] == riscv_v_pkg::OPC_OPV) && (w[14:12] == 3'b111) && !w[31];
            if (ext_csr_req_id.wr_vl || ext_csr_req_id.wr_vtype) begin
                nxt_csr.req = ext_csr_req_id;
            end else begin
                nxt_csr.req.wr_vl      = vset;
                nxt_csr.req.wr_vtype   = vset;
                nxt_csr.req.vl_data    = vl_clamp(int_rf_rd_data_id);
                nxt_csr.req.vtype_data = w[27:20];
            end
            nxt_csr.int_en   = vset && (w[11:7] != 5'd0);
            nxt_csr.int_data = vl_clamp(int_rf_rd_data_id);
            if (wb_r.ctrl.valid) begin
                shadow[wb_r.vd] = wb_r.result;
                known[wb_r.vd]  = wb_r.res_known;
            end
            if (csr_wb.req.wr_vl) sh_vl = csr_wb.req.vl_data;
            if (csr_wb.req.wr_vtype) sh_vtype = csr_wb.req.vtype_data;
            wb_r    = clear_pipe ? '0 : exe_r;
            exe_r   = clear_pipe ? '0 : nxt_exe;
            csr_wb  = clear_pipe ? '0 : csr_exe;
            csr_exe = clear_pipe ? '0 : nxt_csr;
        end
    end

    // Mid-cycle comparison against the shadow state
    always @(negedge clk) begin
        if (rst_n) begin
            assert (exe_ctrl == exe_r.ctrl) else begin
                err_ctrl++;
                $display("Fail %0t: exe_ctrl %h expected %h", $time, exe_ctrl, exe_r.ctrl);
            end
            if (exe_r.ctrl.valid) begin
                assert (imm_exe == exe_r.imm) else begin
                    err_ctrl++;
                    $display("Fail %0t: imm_exe %h expected %h", $time, imm_exe, exe_r.imm);
                end
                if (exe_r.ctrl.is_vector_vector_op && exe_r.a_known) begin
                    assert (rf_rd_data_srca_exe == exe_r.srca) else begin
                        err_data++;
                        $display("Fail %0t: srca %h expected %h", $time,
                                 rf_rd_data_srca_exe, exe_r.srca);
                    end
                end
                if (exe_r.b_known) begin
                    assert (rf_rd_data_srcb_exe == exe_r.srcb) else begin
                        err_data++;
                        $display("Fail %0t: srcb %h expected %h", $time,
                                 rf_rd_data_srcb_exe, exe_r.srcb);
                    end
                end
                if (exe_r.ctrl.is_vector_scalar_op) begin
                    assert (int_rf_rd_data_exe == exe_r.int_val) else begin
                        err_data++;
                        $display("Fail %0t: scalar %h expected %h", $time,
                                 int_rf_rd_data_exe, exe_r.int_val);
                    end
                end
            end
            assert (vl == sh_vl && vtype == sh_vtype && vlenb == 32'(VLEN / 8)) else begin
                err_csr++;
                $display("Fail %0t: vl %0d vtype %h vlenb %0d expected %0d %h %0d", $time,
                         vl, vtype, vlenb, sh_vl, sh_vtype, VLEN / 8);
            end
            assert (int_rf_wr_en_wb == (csr_wb.int_en && !riscv_stall)) else begin
                err_csr++;
                $display("Fail %0t: int_rf_wr_en_wb %b", $time, int_rf_wr_en_wb);
            end
            if (int_rf_wr_en_wb) begin
                assert (int_rf_wr_data_wb == csr_wb.int_data) else begin
                    err_csr++;
                    $display("Fail %0t: int write-back %0d expected %0d", $time,
                             int_rf_wr_data_wb, csr_wb.int_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TEST_CYCLES + 200) begin
            $display("Timeout: stimulus did not complete within %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic drive(input logic [31:0] word, input logic [31:0] iv,
                         input riscv_v_pkg::riscv_v_csr_req_t ext,
                         input logic st, input logic fl);
        @(posedge clk);
        #2;
        instruction_id    = word;
        int_rf_rd_data_id = iv;
        ext_csr_req_id    = ext;
        riscv_stall       = st;
        clear_pipe        = fl;
    endtask

    task automatic bubbles(input int n);
        repeat (n) drive(BUBBLE, lcg_next(), '0, 1'b0, 1'b0);
    endtask

    function automatic logic [31:0] enc_opv(input logic [5:0] f6, input logic [2:0] f3,
                                            input logic [4:0] vd, input logic [4:0] vs1,
                                            input logic [4:0] vs2);
        return {f6, 1'b1, vs2, vs1, f3, vd, riscv_v_pkg::OPC_OPV};
    endfunction

    function automatic logic [31:0] enc_vsetvli(input logic [10:0] zimm,
                                                input logic [4:0] rd);
        return {1'b0, zimm, 5'd1, 3'b111, rd, riscv_v_pkg::OPC_OPV};
    endfunction

    function automatic logic [31:0] rand_alu();
        logic [31:0] r;
        logic [5:0]  f6;
        logic [2:0]  f3;
        r = lcg_next();
        case (r[2:0] % 5)
            0: f6 = riscv_v_pkg::F6_VADD;
            1: f6 = riscv_v_pkg::F6_VSUB;
            2: f6 = riscv_v_pkg::F6_VAND;
            3: f6 = riscv_v_pkg::F6_VOR;
            default: f6 = riscv_v_pkg::F6_VXOR;
        endcase
        case (r[5:4])
            0: f3 = riscv_v_pkg::F3_OPIVX;
            1: f3 = riscv_v_pkg::F3_OPIVI;
            default: f3 = riscv_v_pkg::F3_OPIVV;
        endcase
        return enc_opv(f6, f3, r[12:8], r[20:16], r[28:24]);
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] a_word;
        riscv_v_pkg::riscv_v_csr_req_t ext;
        rst_n = 1'b0;
        clear_pipe = 1'b0;
        riscv_stall = 1'b0;
        instruction_id = BUBBLE;
        int_rf_rd_data_id = '0;
        ext_csr_req_id = '0;
        cycles = 0;
        err_ctrl = 0;
        err_data = 0;
        err_csr = 0;
        for (int i = 0; i < 32; i++) known[i] = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Clear every register and then seed it from the scalar path
        for (int i = 0; i < 32; i++) begin
            drive(enc_opv(riscv_v_pkg::F6_VAND, riscv_v_pkg::F3_OPIVI, 5'(i), 5'd0, 5'(i)),
                  '0, '0, 1'b0, 1'b0);
            bubbles(2);
        end
        for (int i = 0; i < 32; i++) begin
            drive(enc_opv(riscv_v_pkg::F6_VOR, riscv_v_pkg::F3_OPIVX, 5'(i), 5'd0, 5'(i)),
                  lcg_next(), '0, 1'b0, 1'b0);
            bubbles(2);
        end
        for (int i = 0; i < N_ALU; i++) begin
            drive(rand_alu(), lcg_next(), '0, 1'b0, 1'b0);
            bubbles(2);
        end
        // Random legal and illegal words back to back
        for (int i = 0; i < N_DEC; i++) begin
            r = lcg_next();
            if (r[1:0] == 2'b00) r = lcg_next();
            else if (r[1:0] == 2'b01) r = {r[31:7], riscv_v_pkg::OPC_OPV};
            else r = rand_alu();
            drive(r, lcg_next(), '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < N_VSET; i++) begin
            r = lcg_next();
            drive(enc_vsetvli(r[10:0], (r[13:12] == 2'b00) ? 5'd0 : r[20:16]),
                  lcg_next() % 24, '0, 1'b0, 1'b0);
            bubbles(3);
        end
        // External request collides with vsetvli
        for (int i = 0; i < N_ARB; i++) begin
            r = lcg_next();
            ext.wr_vl      = 1'b1;
            ext.wr_vtype   = r[0];
            ext.vl_data    = lcg_next();
            ext.vtype_data = r[15:8];
            drive(enc_vsetvli(r[26:16], r[31:27]), lcg_next() % 24, ext, 1'b0, 1'b0);
            bubbles(3);
        end
        for (int i = 0; i < N_SF; i++) begin
            r = lcg_next();
            a_word = rand_alu();
            // vsetvli waits in write-back during the first stall
            drive(enc_vsetvli(r[26:16], r[31:27]), lcg_next() % 24, '0, 1'b0, 1'b0);
            drive(a_word, lcg_next(), '0, 1'b0, 1'b0);
            repeat (3) drive(rand_alu(), lcg_next(), '0, 1'b1, 1'b0);
            drive(BUBBLE, lcg_next(), '0, 1'b0, 1'b0);
            // ALU result waits in write-back during the second stall
            repeat (2) drive(rand_alu(), lcg_next(), '0, 1'b1, 1'b0);
            drive(enc_opv(riscv_v_pkg::F6_VOR, riscv_v_pkg::F3_OPIVV, r[12:8], a_word[11:7],
                          a_word[11:7]), '0, '0, 1'b0, 1'b0);
            bubbles(2);
            drive(enc_opv(riscv_v_pkg::F6_VXOR, riscv_v_pkg::F3_OPIVX, r[4:0], 5'd0, r[4:0]),
                  lcg_next(), '0, 1'b0, 1'b0);
            drive(BUBBLE, '0, '0, 1'b0, 1'b1);
            bubbles(2);
            drive(enc_opv(riscv_v_pkg::F6_VOR, riscv_v_pkg::F3_OPIVV, r[12:8], r[4:0], r[4:0]),
                  '0, '0, 1'b0, 1'b0);
            bubbles(2);
        end
        bubbles(10);
        $display("Errors: decode %0d, register data %0d, csr %0d", err_ctrl, err_data, err_csr);
        if (err_ctrl + err_data + err_csr == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: riscv_v_decode.f
+incdir+test
common/riscv_v_pkg.sv
design/riscv_v_ctrl.sv
regfile/riscv_v_rf.sv
regfile/riscv_v_rf_ctrl.sv
csr/riscv_v_csr_ctrl.sv
csr/riscv_v_csr.sv
design/riscv_v_decode.sv
test/riscv_v_decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= riscv_v_decode_tb
FILELIST  ?= riscv_v_decode.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') test/riscv_v_model.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^test passed$$'

clean:
	rm -rf $(BUILD_DIR)
